/* Bender.yml */
package:
  name: ex_stage

sources:
  - files:
      - hw/ex_pkg.sv
      - hw/ex_ctl.sv
      - hw/ex_dpath.sv
      - hw/ex_imdr.sv
      - hw/ex_regs.sv
      - hw/ex.sv
  - target: simulation
    files:
      - verification/ex_asserts.sv
      - verification/ex_checker.sv
      - verification/ex_tb.sv

/* hw/ex.sv */
// Execute-stage top level: control, datapath, mul/div unit and VARS/PSR registers
module ex (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      valid_op_e,
   input  ex_pkg::ex_op_e            opcode_e,
   input  logic [ex_pkg::DATA_W-1:0] a_e,          // value1
   input  logic [ex_pkg::DATA_W-1:0] b_e,          // value2
   input  logic                      hold_e,
   output logic                      busy_e,
   output logic                      result_vld_w,
   output logic [ex_pkg::DATA_W-1:0] alu_out_w,
   output logic                      div0_w,
   output logic                      illegal_op_w,
   output logic [ex_pkg::DATA_W-1:0] vars_out,
   output logic [ex_pkg::DATA_W-1:0] psr_out
);
   import ex_pkg::*;

   alu_sel_e          alu_sel;         // Result source
   logic              sub_e;
   logic [1:0]        bit_fn;
   logic [1:0]        shift_fn;
   logic              issue_w;         // Single-cycle result load
   logic              imdr_start;
   imdr_fn_e          imdr_fn;
   logic              vars_we;
   logic              psr_we;
   logic              reg_rd_psr;
   logic [DATA_W-1:0] reg_data_e;      // VARS/PSR read data
   logic              imdr_busy;
   logic              imdr_done;
   logic              imdr_div0;
   logic [DATA_W-1:0] imdr_data;

   ex_ctl u_ctl (
      .clk          (clk),
      .reset        (reset),
      .valid_op_e   (valid_op_e),
      .hold_e       (hold_e),
      .opcode_e     (opcode_e),
      .imdr_busy    (imdr_busy),
      .alu_sel      (alu_sel),
      .sub_e        (sub_e),
      .bit_fn       (bit_fn),
      .shift_fn     (shift_fn),
      .issue_w      (issue_w),
      .imdr_start   (imdr_start),
      .imdr_fn      (imdr_fn),
      .vars_we      (vars_we),
      .psr_we       (psr_we),
      .reg_rd_psr   (reg_rd_psr),
      .illegal_op_w (illegal_op_w),
      .busy_e       (busy_e)
   );

   ex_dpath u_dpath (
      .clk          (clk),
      .reset        (reset),
      .a_e          (a_e),
      .b_e          (b_e),
      .alu_sel      (alu_sel),
      .sub_e        (sub_e),
      .bit_fn       (bit_fn),
      .shift_fn     (shift_fn),
      .issue_w      (issue_w),
      .reg_data_e   (reg_data_e),
      .imdr_done    (imdr_done),
      .imdr_div0    (imdr_div0),
      .imdr_data    (imdr_data),
      .alu_out_w    (alu_out_w),
      .result_vld_w (result_vld_w),
      .div0_w       (div0_w)
   );

   ex_imdr u_imdr (
      .clk          (clk),
      .reset        (reset),
      .hold_e       (hold_e),          // Same hold stalls the iteration
      .imdr_start   (imdr_start),
      .imdr_fn      (imdr_fn),
      .a_e          (a_e),
      .b_e          (b_e),
      .imdr_busy    (imdr_busy),
      .imdr_done    (imdr_done),
      .imdr_div0    (imdr_div0),
      .imdr_data    (imdr_data)
   );

   ex_regs u_regs (
      .clk          (clk),
      .reset        (reset),
      .vars_we      (vars_we),
      .psr_we       (psr_we),
      .reg_rd_psr   (reg_rd_psr),
      .a_e          (a_e),           // Write data is value1
      .reg_data_e   (reg_data_e),
      .vars_out     (vars_out),
      .psr_out      (psr_out)
   );

endmodule

/* hw/ex_ctl.sv */
// Execute-stage control: issue gating, opcode decode, select and write-enable strobes
module ex_ctl (
   input  logic             clk,
   input  logic             reset,
   input  logic             valid_op_e,
   input  logic             hold_e,
   input  ex_pkg::ex_op_e   opcode_e,
   input  logic             imdr_busy,
   output ex_pkg::alu_sel_e alu_sel,
   output logic             sub_e,
   output logic [1:0]       bit_fn,
   output logic [1:0]       shift_fn,
   output logic             issue_w,
   output logic             imdr_start,
   output ex_pkg::imdr_fn_e imdr_fn,
   output logic             vars_we,
   output logic             psr_we,
   output logic             reg_rd_psr,
   output logic             illegal_op_w,
   output logic             busy_e
);
   import ex_pkg::*;

   logic accept_e;                       // Operation taken at this edge
   logic single_e;                       // Result ready in one cycle
   logic imdr_op_e;                      // Goes to the mul/div unit
   logic wr_vars_e;
   logic wr_psr_e;
   logic illegal_e;                      // Unassigned opcode

   assign busy_e   = imdr_busy;          // Stall issue while mul/div runs
   assign accept_e = valid_op_e & ~hold_e & ~busy_e;

   always_comb begin
      alu_sel    = SEL_ADDER;            // Defaults for an add
      sub_e      = 1'b0;
      bit_fn     = BIT_AND;
      shift_fn   = SH_LEFT;
      imdr_fn    = IMDR_MUL;
      reg_rd_psr = 1'b0;
      single_e   = 1'b1;
      imdr_op_e  = 1'b0;
      wr_vars_e  = 1'b0;
      wr_psr_e   = 1'b0;
      illegal_e  = 1'b0;
      case (opcode_e)
         OP_ADD:     sub_e = 1'b0;
         OP_SUB:     sub_e = 1'b1;    // a + ~b + 1
         OP_AND: begin
            alu_sel = SEL_BIT;
            bit_fn  = BIT_AND;
         end
         OP_OR: begin
            alu_sel = SEL_BIT;
            bit_fn  = BIT_OR;
         end
         OP_XOR: begin
            alu_sel = SEL_BIT;
            bit_fn  = BIT_XOR;
         end
         OP_SHL: begin
            alu_sel  = SEL_SHIFT;
            shift_fn = SH_LEFT;
         end
         OP_SHR: begin
            alu_sel  = SEL_SHIFT;
            shift_fn = SH_ARITH;
         end
         OP_USHR: begin
            alu_sel  = SEL_SHIFT;
            shift_fn = SH_LOGIC;
         end
         OP_CMP:     alu_sel = SEL_CMP;
         OP_MUL, OP_DIV, OP_REM: begin
            single_e  = 1'b0;
            imdr_op_e = 1'b1;
            imdr_fn   = (opcode_e == OP_MUL) ? IMDR_MUL :
                        (opcode_e == OP_DIV) ? IMDR_DIV : IMDR_REM;
         end
         OP_RD_VARS: alu_sel = SEL_REG;
         OP_RD_PSR: begin
            alu_sel    = SEL_REG;
            reg_rd_psr = 1'b1;        // Else VARS on the read mux
         end
         OP_WR_VARS: begin
            single_e  = 1'b0;         // Writes give no result strobe
            wr_vars_e = 1'b1;
         end
         OP_WR_PSR: begin
            single_e = 1'b0;
            wr_psr_e = 1'b1;
         end
         default: begin
            single_e  = 1'b0;
            illegal_e = 1'b1;
         end
      endcase
   end

   assign issue_w    = accept_e & single_e;   // W register load at this edge
   assign imdr_start = accept_e & imdr_op_e;
   assign vars_we    = accept_e & wr_vars_e;
   assign psr_we     = accept_e & wr_psr_e;

   always_ff @(posedge clk) begin
      if (reset) begin
         illegal_op_w <= 1'b0;
      end else begin
         illegal_op_w <= accept_e & illegal_e; // One-cycle flag in W
      end
   end

endmodule

/* hw/ex_dpath.sv */
// Execute-stage datapath: adder, comparator, bitwise unit, shifter, result mux, W register
module ex_dpath (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [ex_pkg::DATA_W-1:0] a_e,
   input  logic [ex_pkg::DATA_W-1:0] b_e,
   input  ex_pkg::alu_sel_e          alu_sel,
   input  logic                      sub_e,
   input  logic [1:0]                bit_fn,
   input  logic [1:0]                shift_fn,
   input  logic                      issue_w,
   input  logic [ex_pkg::DATA_W-1:0] reg_data_e,
   input  logic                      imdr_done,
   input  logic                      imdr_div0,
   input  logic [ex_pkg::DATA_W-1:0] imdr_data,
   output logic [ex_pkg::DATA_W-1:0] alu_out_w,
   output logic                      result_vld_w,
   output logic                      div0_w
);
   import ex_pkg::*;

   logic [DATA_W-1:0]  b_op;             // b or its complement
   logic [DATA_W-1:0]  sum_e;
   logic [DATA_W-1:0]  bit_e;
   logic [DATA_W-1:0]  shift_e;
   logic [DATA_W-1:0]  cmp_e;
   logic [DATA_W-1:0]  result_e;         // E-stage result mux output
   logic [SHAMT_W-1:0] shamt;
   logic               lt_e;
   logic               eq_e;

   assign b_op  = sub_e ? ~b_e : b_e;
   assign sum_e = a_e + b_op + {{(DATA_W-1){1'b0}}, sub_e}; // Carry in completes negate

   assign lt_e  = $signed(a_e) < $signed(b_e);
   assign eq_e  = (a_e == b_e);
   assign cmp_e = lt_e ? {DATA_W{1'b1}} :                // -1
                  eq_e ? {DATA_W{1'b0}} :                //  0
                         {{(DATA_W-1){1'b0}}, 1'b1};     // +1

   assign shamt = b_e[SHAMT_W-1:0];                      // Upper bits of b ignored

   always_comb begin
      case (bit_fn)
         BIT_OR:  bit_e = a_e | b_e;
         BIT_XOR: bit_e = a_e ^ b_e;
         default: bit_e = a_e & b_e;
      endcase
   end

   always_comb begin
      case (shift_fn)
         SH_ARITH: shift_e = $signed(a_e) >>> shamt;    // Sign of a shifts in
         SH_LOGIC: shift_e = a_e >> shamt;
         default:  shift_e = a_e << shamt;
      endcase
   end

   always_comb begin
      case (alu_sel)
         SEL_BIT:   result_e = bit_e;
         SEL_SHIFT: result_e = shift_e;
         SEL_CMP:   result_e = cmp_e;
         SEL_REG:   result_e = reg_data_e;               // VARS or PSR read
         default:   result_e = sum_e;
      endcase
   end

   // W stage, holds last result between strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         alu_out_w    <= '0;
         result_vld_w <= 1'b0;
         div0_w       <= 1'b0;
      end else begin
         result_vld_w <= issue_w | imdr_done;
         div0_w       <= imdr_done & imdr_div0;
         if (issue_w) begin
            alu_out_w <= result_e;
         end else if (imdr_done) begin
            alu_out_w <= imdr_data;                      // Never with issue_w, busy blocks it
         end
      end
   end

endmodule

/* hw/ex_imdr.sv */
// Iterative signed multiply/divide/remainder unit with busy, done and divide-by-zero
module ex_imdr (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      hold_e,
   input  logic                      imdr_start,
   input  ex_pkg::imdr_fn_e          imdr_fn,
   input  logic [ex_pkg::DATA_W-1:0] a_e,
   input  logic [ex_pkg::DATA_W-1:0] b_e,
   output logic                      imdr_busy,
   output logic                      imdr_done,
   output logic                      imdr_div0,
   output logic [ex_pkg::DATA_W-1:0] imdr_data
);
   import ex_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,                            // One step per cycle
      ST_DONE                            // Result on imdr_data
   } imdr_st_e;

   imdr_st_e              state;
   logic [IMDR_CNT_W-1:0] cnt;           // Step counter
   logic                  div0_q;
   imdr_fn_e              fn_q;
   logic                  neg_q;         // Product/quotient negative
   logic                  neg_r;         // Remainder follows a
   logic [DATA_W-1:0]     acc;           // Partial product or remainder
   logic [DATA_W-1:0]     opq;           // Multiplier or dividend/quotient
   logic [DATA_W-1:0]     opd;           // Multiplicand or divisor
   logic [DATA_W:0]       trial;         // Restoring subtract
   logic [DATA_W-1:0]     mag_a;
   logic [DATA_W-1:0]     mag_b;
   logic [DATA_W-1:0]     raw;           // Unsigned result before sign
   logic                  start_div0;
   logic                  neg_res;

   assign mag_a      = a_e[DATA_W-1] ? -a_e : a_e;   // Min value maps to 2^31 unsigned
   assign mag_b      = b_e[DATA_W-1] ? -b_e : b_e;
   assign start_div0 = (imdr_fn != IMDR_MUL) && (b_e == '0);
   assign trial      = {acc, opq[DATA_W-1]} - {1'b0, opd};

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= ST_IDLE;
         cnt    <= '0;
         div0_q <= 1'b0;
      end else if (!hold_e) begin        // Frozen under hold
         case (state)
            ST_IDLE: begin
               if (imdr_start) begin
                  cnt    <= '0;
                  div0_q <= start_div0;
                  state  <= start_div0 ? ST_DONE : ST_RUN; // Zero divisor skips the loop
               end
            end
            ST_RUN: begin
               cnt <= cnt + 1'b1;
               if (cnt == IMDR_CNT_W'(IMDR_STEPS - 1)) begin
                  state <= ST_DONE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && imdr_start && !hold_e) begin
         fn_q  <= imdr_fn;
         neg_q <= a_e[DATA_W-1] ^ b_e[DATA_W-1];
         neg_r <= a_e[DATA_W-1];
         acc   <= '0;
         opq   <= start_div0 ? '0 : mag_a;          // Zeroed so the result reads 0
         opd   <= mag_b;
      end else if (state == ST_RUN && !hold_e) begin
         if (fn_q == IMDR_MUL) begin
            if (opq[0]) begin
               acc <= acc + opd;                     // Low 32 bits kept
            end
            opd <= opd << 1;
            opq <= opq >> 1;
         end else begin
            if (!trial[DATA_W]) begin
               acc <= trial[DATA_W-1:0];             // Divisor fits
            end else begin
               acc <= {acc[DATA_W-2:0], opq[DATA_W-1]}; // Restore, shift only
            end
            opq <= {opq[DATA_W-2:0], ~trial[DATA_W]};   // Quotient bit in
         end
      end
   end

   always_comb begin
      case (fn_q)
         IMDR_DIV: begin
            raw     = opq;
            neg_res = neg_q;
         end
         IMDR_REM: begin
            raw     = acc;
            neg_res = neg_r;
         end
         default: begin
            raw     = acc;
            neg_res = neg_q;
         end
      endcase
      imdr_data = neg_res ? -raw : raw;              // Truncates toward zero
   end

   assign imdr_busy = (state != ST_IDLE);
   assign imdr_done = (state == ST_DONE) & ~hold_e;
   assign imdr_div0 = div0_q;

endmodule

/* hw/ex_pkg.sv */
// Execute-stage package: widths, opcode and select enums, bit/shift codes, PSR reset value
package ex_pkg;

   localparam int DATA_W     = 32;                 // Operand and result width
   localparam int SHAMT_W    = 5;                  // Shift count taken from b
   localparam int IMDR_STEPS = 32;                 // One step per result bit
   localparam int IMDR_CNT_W = $clog2(IMDR_STEPS); // Step counter width
   localparam int OP_W       = 5;                  // Opcode field width

   // ACE and SU mode bits come up set
   localparam logic [DATA_W-1:0] PSR_RESET = 32'h0000_2020;

   localparam logic [1:0] BIT_AND  = 2'd0;         // Bitwise unit functions
   localparam logic [1:0] BIT_OR   = 2'd1;
   localparam logic [1:0] BIT_XOR  = 2'd2;

   localparam logic [1:0] SH_LEFT  = 2'd0;         // Shifter functions
   localparam logic [1:0] SH_ARITH = 2'd1;         // Sign fill
   localparam logic [1:0] SH_LOGIC = 2'd2;         // Zero fill

   // Codes 16 to 31 are unassigned and decode as illegal
   typedef enum logic [OP_W-1:0] {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SHL,
      OP_SHR,                                      // Arithmetic right
      OP_USHR,                                     // Logical right
      OP_CMP,                                      // Signed -1/0/+1
      OP_MUL,
      OP_DIV,
      OP_REM,
      OP_RD_VARS,
      OP_WR_VARS,
      OP_RD_PSR,
      OP_WR_PSR
   } ex_op_e;

   typedef enum logic [2:0] {
      SEL_ADDER,
      SEL_BIT,
      SEL_SHIFT,
      SEL_CMP,
      SEL_REG
   } alu_sel_e;

   typedef enum logic [1:0] {
      IMDR_MUL,
      IMDR_DIV,
      IMDR_REM
   } imdr_fn_e;

endpackage

/* hw/ex_regs.sv */
// VARS and PSR registers with write enables and read mux
module ex_regs (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      vars_we,
   input  logic                      psr_we,
   input  logic                      reg_rd_psr,
   input  logic [ex_pkg::DATA_W-1:0] a_e,
   output logic [ex_pkg::DATA_W-1:0] reg_data_e,
   output logic [ex_pkg::DATA_W-1:0] vars_out,
   output logic [ex_pkg::DATA_W-1:0] psr_out
);
   import ex_pkg::*;

   always_ff @(posedge clk) begin
      if (reset) begin
         vars_out <= '0;
      end else if (vars_we) begin
         vars_out <= a_e;                // Local variable base
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         psr_out <= PSR_RESET;           // Mode bits up at reset
      end else if (psr_we) begin
         psr_out <= a_e;
      end
   end

   // Read mux for the read opcodes, sampled into W by the datapath
   assign reg_data_e = reg_rd_psr ? psr_out : vars_out;

endmodule

/* src.f */
hw/ex_pkg.sv
hw/ex_ctl.sv
hw/ex_dpath.sv
hw/ex_imdr.sv
hw/ex_regs.sv
hw/ex.sv
verification/ex_asserts.sv
verification/ex_checker.sv
verification/ex_tb.sv

/* verification/ex_asserts.sv */
// Concurrent assertions on the execute-stage control outputs, with the bind into ex
module ex_asserts (
   input logic clk,
   input logic reset,
   input logic busy_e,
   input logic result_vld_w,
   input logic illegal_op_w,
   input logic div0_w
);
   int fails = 0;                                 // Failed assertion count

   vld_ill_excl: assert property (@(posedge clk) disable iff (reset)
                                  !(result_vld_w && illegal_op_w))
      else begin
         $error("result_vld_w and illegal_op_w high together");
         fails++;
      end

   div0_has_vld: assert property (@(posedge clk) disable iff (reset)
                                  div0_w |-> result_vld_w)
      else begin
         $error("div0_w high without result_vld_w");
         fails++;
      end

   idle_after_reset: assert property (@(posedge clk) reset |=> !busy_e)
      else begin
         $error("busy_e high in the cycle after reset");
         fails++;
      end

endmodule

bind ex ex_asserts asserts_i (
   .clk          (clk),
   .reset        (reset),
   .busy_e       (busy_e),
   .result_vld_w (result_vld_w),
   .illegal_op_w (illegal_op_w),
   .div0_w       (div0_w)
);

/* verification/ex_checker.sv */
// Checker: reference model of accepted operations, result queue, value and flag comparison
module ex_checker (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      valid_op_e,
   input  logic                      hold_e,
   input  ex_pkg::ex_op_e            opcode_e,
   input  logic [ex_pkg::DATA_W-1:0] a_e,
   input  logic [ex_pkg::DATA_W-1:0] b_e,
   input  logic                      busy_e,
   input  logic                      result_vld_w,
   input  logic [ex_pkg::DATA_W-1:0] alu_out_w,
   input  logic                      div0_w,
   input  logic                      illegal_op_w,
   input  logic [ex_pkg::DATA_W-1:0] vars_out,
   input  logic [ex_pkg::DATA_W-1:0] psr_out,
   input  logic [63:0]               test_name,
   input  logic                      exp_known,
   input  logic [ex_pkg::DATA_W-1:0] exp_val,
   input  logic                      exp_div0,
   output int                        val_errs,
   output int                        other_errs,
   output int                        pending
);
   import ex_pkg::*;

   typedef struct packed {
      logic [63:0]       name;
      logic [DATA_W-1:0] val;
      logic              div0;
   } exp_t;

   exp_t              res_q[$];                   // Outstanding results in issue order
   logic              single_due;                 // Result owed at this edge
   logic              ill_due;
   int                reg_due;                    // 1 VARS, 2 PSR
   logic [DATA_W-1:0] reg_exp;
   logic [63:0]       last_name;
   logic [DATA_W-1:0] m_vars;                     // Model registers
   logic [DATA_W-1:0] m_psr;
   logic              after_reset;

   // 0 single cycle, 1 mul/div, 2 VARS write, 3 PSR write, 4 illegal
   function automatic int op_kind(input ex_op_e op);
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_USHR, OP_CMP,
         OP_RD_VARS, OP_RD_PSR: return 0;
         OP_MUL, OP_DIV, OP_REM: return 1;
         OP_WR_VARS: return 2;
         OP_WR_PSR: return 3;
         default: return 4;
      endcase
   endfunction

   function automatic logic [DATA_W-1:0] model_result(input ex_op_e op,
                                                      input logic [DATA_W-1:0] a,
                                                      input logic [DATA_W-1:0] b);
      logic [SHAMT_W-1:0] sh;
      logic               min_by_m1;
      sh        = b[SHAMT_W-1:0];
      min_by_m1 = (a == 32'h8000_0000) && (b == 32'hffff_ffff); // Overflowing divide
      case (op)
         OP_ADD:     return a + b;
         OP_SUB:     return a - b;
         OP_AND:     return a & b;
         OP_OR:      return a | b;
         OP_XOR:     return a ^ b;
         OP_SHL:     return a << sh;
         OP_SHR:     return $signed(a) >>> sh;
         OP_USHR:    return a >> sh;
         OP_MUL:     return a * b;                // Low word same signed or not
         OP_RD_VARS: return m_vars;
         OP_RD_PSR:  return m_psr;
         OP_CMP: begin
            if ($signed(a) < $signed(b)) return '1;
            if (a == b) return '0;
            return 1;
         end
         OP_DIV: begin
            if (b == '0) return '0;
            if (min_by_m1) return a;
            return $signed(a) / $signed(b);       // Truncates toward zero
         end
         OP_REM: begin
            if (b == '0 || min_by_m1) return '0;
            return $signed(a) % $signed(b);       // Sign of a
         end
         default:    return '0;
      endcase
   endfunction

   task automatic check_val(input logic [63:0] name, input string what,
                            input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("ERR %0s %0s: expected %h, got %h", name, what, exp, act);
         val_errs++;
      end
   endtask

   // Outputs seen at this edge belong to operations accepted at earlier edges
   task automatic check_outputs();
      exp_t head;
      if (single_due && !result_vld_w) begin
         $display("Result of %0s missing one cycle after issue", last_name);
         other_errs++;
      end
      if (result_vld_w) begin
         if (res_q.size() == 0) begin
            $display("Result strobe with no operation outstanding");
            other_errs++;
         end else begin
            head = res_q.pop_front();
            check_val(head.name, "alu_out_w", head.val, alu_out_w);
            check_val(head.name, "div0_w", head.div0, div0_w);
         end
      end
      check_val(last_name, "illegal_op_w", ill_due, illegal_op_w);
      if (reg_due == 1) begin
         check_val(last_name, "vars_out", reg_exp, vars_out);
      end
      if (reg_due == 2) begin
         check_val(last_name, "psr_out", reg_exp, psr_out);
      end
      single_due = 1'b0;
      ill_due    = 1'b0;
      reg_due    = 0;
   endtask

   task automatic take_op();
      exp_t e;
      int   kind;
      kind      = op_kind(opcode_e);
      last_name = test_name;
      e.name    = test_name;
      case (kind)
         0, 1: begin
            e.val      = exp_known ? exp_val : model_result(opcode_e, a_e, b_e);
            e.div0     = exp_known ? exp_div0 : (kind == 1 && opcode_e != OP_MUL && b_e == '0);
            single_due = (kind == 0);
            res_q.push_back(e);
         end
         2: begin
            reg_exp = exp_known ? exp_val : a_e;  // Written from value1
            m_vars  = reg_exp;
            reg_due = 1;
         end
         3: begin
            reg_exp = exp_known ? exp_val : a_e;
            m_psr   = reg_exp;
            reg_due = 2;
         end
         default: ill_due = 1'b1;
      endcase
   endtask

   always @(posedge clk) begin
      if (reset) begin
         res_q.delete();
         single_due  = 1'b0;
         ill_due     = 1'b0;
         reg_due     = 0;
         last_name   = "reset";
         m_vars      = '0;
         m_psr       = PSR_RESET;
         after_reset = 1'b1;
         val_errs    = 0;
         other_errs  = 0;
      end else begin
         if (after_reset) begin
            check_val("reset", "vars_out", '0, vars_out);
            check_val("reset", "psr_out", PSR_RESET, psr_out);
            check_val("reset", "alu_out_w", '0, alu_out_w);
            after_reset = 1'b0;
         end
         check_outputs();
         if (valid_op_e && !hold_e && !busy_e) begin // Issue rule
            take_op();
         end
      end
      pending = res_q.size();
   end

endmodule

/* verification/ex_tb.sv */
// Testbench top with clock, reset, stimulus table and LCG entries, watchdog, DUT and checker
module ex_tb;
   import ex_pkg::*;

   localparam int N_RAND = 40;                    // Random entries after the fixed table

   typedef struct packed {
      logic [63:0]       name;                    // Up to eight characters
      ex_op_e            op;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic [DATA_W-1:0] exp;                     // Result or written register value
      logic              div0;
      logic [3:0]        hold;                    // Hold cycles before issue
      logic              known;                   // Else the checker model supplies it
   } entry_t;

   logic              clk;
   logic              reset;
   logic              valid_op_e;
   logic              hold_e;
   ex_op_e            opcode_e;
   logic [DATA_W-1:0] a_e;
   logic [DATA_W-1:0] b_e;
   logic              busy_e;
   logic              result_vld_w;
   logic [DATA_W-1:0] alu_out_w;
   logic              div0_w;
   logic              illegal_op_w;
   logic [DATA_W-1:0] vars_out;
   logic [DATA_W-1:0] psr_out;
   logic [63:0]       test_name;                  // Name of the entry on the inputs
   logic              exp_known;
   logic [DATA_W-1:0] exp_val;
   logic              exp_div0;
   int                val_errs;
   int                other_errs;
   int                pending;
   int                asrt_fails;
   int                limit;                      // Watchdog length in cycles
   logic              built;
   logic [31:0]       seed;
   entry_t            tbl[$];

   always #5 clk = ~clk;

   ex dut_i (
      .clk          (clk),
      .reset        (reset),
      .valid_op_e   (valid_op_e),
      .opcode_e     (opcode_e),
      .a_e          (a_e),
      .b_e          (b_e),
      .hold_e       (hold_e),
      .busy_e       (busy_e),
      .result_vld_w (result_vld_w),
      .alu_out_w    (alu_out_w),
      .div0_w       (div0_w),
      .illegal_op_w (illegal_op_w),
      .vars_out     (vars_out),
      .psr_out      (psr_out)
   );

   ex_checker chk_i (
      .clk          (clk),
      .reset        (reset),
      .valid_op_e   (valid_op_e),
      .hold_e       (hold_e),
      .opcode_e     (opcode_e),
      .a_e          (a_e),
      .b_e          (b_e),
      .busy_e       (busy_e),
      .result_vld_w (result_vld_w),
      .alu_out_w    (alu_out_w),
      .div0_w       (div0_w),
      .illegal_op_w (illegal_op_w),
      .vars_out     (vars_out),
      .psr_out      (psr_out),
      .test_name    (test_name),
      .exp_known    (exp_known),
      .exp_val      (exp_val),
      .exp_div0     (exp_div0),
      .val_errs     (val_errs),
      .other_errs   (other_errs),
      .pending      (pending)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic push_entry(input logic [63:0] name, input ex_op_e op,
                             input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                             input logic [DATA_W-1:0] exp, input logic div0,
                             input logic [3:0] hold);
      tbl.push_back({name, op, a, b, exp, div0, hold, 1'b1});
   endtask

   task automatic add_random();
      entry_t e;
      e      = '0;
      e.name = "random";
      seed   = lcg_next(seed);
      e.op   = ex_op_e'(OP_W'((seed >> 16) % 16)); // Any assigned opcode
      seed   = lcg_next(seed);
      e.a    = seed;
      seed   = lcg_next(seed);
      e.b    = seed >> seed[4:0];                  // Wide spread of magnitudes with zero now and then
      tbl.push_back(e);
   endtask

   task automatic build_table();
      push_entry("rdpsr0", OP_RD_PSR, 32'h0, 32'h0, PSR_RESET, 1'b0, 4'd0);
      push_entry("add", OP_ADD, 32'h7fff_ffff, 32'h1, 32'h8000_0000, 1'b0, 4'd0);
      push_entry("sub", OP_SUB, 32'd5, 32'd7, 32'hffff_fffe, 1'b0, 4'd0);
      push_entry("and", OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 1'b0, 4'd0);
      push_entry("or", OP_OR, 32'hf0f0_f0f0, 32'h0f00_000f, 32'hfff0_f0ff, 1'b0, 4'd0);
      push_entry("xor", OP_XOR, 32'haaaa_aaaa, 32'hffff_0000, 32'h5555_aaaa, 1'b0, 4'd0);
      push_entry("cmplt", OP_CMP, 32'hffff_fffd, 32'd2, 32'hffff_ffff, 1'b0, 4'd0);
      push_entry("cmpeq", OP_CMP, 32'd7, 32'd7, 32'h0, 1'b0, 4'd0);
      push_entry("cmpgt", OP_CMP, 32'd2, 32'h8000_0000, 32'h1, 1'b0, 4'd0);
      push_entry("shl", OP_SHL, 32'h1, 32'hffff_ff24, 32'h10, 1'b0, 4'd0);
      push_entry("shr", OP_SHR, 32'h8000_0010, 32'h21, 32'hc000_0008, 1'b0, 4'd0);
      push_entry("ushr", OP_USHR, 32'h8000_0010, 32'h41, 32'h4000_0008, 1'b0, 4'd0);
      push_entry("shr31", OP_SHR, 32'h8000_0000, 32'h1f, 32'hffff_ffff, 1'b0, 4'd0);
      push_entry("mul", OP_MUL, 32'hffff_fff9, 32'd6, 32'hffff_ffd6, 1'b0, 4'd0);
      push_entry("mulneg", OP_MUL, 32'hffff_fffb, 32'hffff_fffb, 32'd25, 1'b0, 4'd0);
      push_entry("mulbig", OP_MUL, 32'h1234_5678, 32'h10, 32'h2345_6780, 1'b0, 4'd0);
      push_entry("div", OP_DIV, 32'hffff_fff9, 32'd2, 32'hffff_fffd, 1'b0, 4'd0);
      push_entry("rem", OP_REM, 32'hffff_fff9, 32'd2, 32'hffff_ffff, 1'b0, 4'd0);
      push_entry("rem2", OP_REM, 32'd7, 32'hffff_fffe, 32'd1, 1'b0, 4'd0);
      push_entry("divmin", OP_DIV, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 1'b0, 4'd0);
      push_entry("remmin", OP_REM, 32'h8000_0000, 32'hffff_ffff, 32'h0, 1'b0, 4'd0);
      push_entry("div0", OP_DIV, 32'd5, 32'h0, 32'h0, 1'b1, 4'd0);
      push_entry("rem0", OP_REM, 32'd5, 32'h0, 32'h0, 1'b1, 4'd0);
      push_entry("wrvars", OP_WR_VARS, 32'h1234_5678, 32'h0, 32'h1234_5678, 1'b0, 4'd0);
      push_entry("rdvars", OP_RD_VARS, 32'h0, 32'h0, 32'h1234_5678, 1'b0, 4'd0);
      push_entry("wrpsr", OP_WR_PSR, 32'hdead_0001, 32'h0, 32'hdead_0001, 1'b0, 4'd3);
      push_entry("rdpsr", OP_RD_PSR, 32'h0, 32'h0, 32'hdead_0001, 1'b0, 4'd0);
      push_entry("illegal", ex_op_e'(5'd20), 32'h0, 32'h0, 32'h0, 1'b0, 4'd0);
      push_entry("addhold", OP_ADD, 32'd1, 32'd2, 32'd3, 1'b0, 4'd4);
      push_entry("mulhold", OP_MUL, 32'd3, 32'd4, 32'd12, 1'b0, 4'd2);
      push_entry("ill31", ex_op_e'(5'd31), 32'h0, 32'h0, 32'h0, 1'b0, 4'd2);
      for (int i = 0; i < N_RAND; i++) begin
         add_random();
      end
   endtask

   // Present one entry on a falling edge and hold it back first where the entry asks
   task automatic apply_entry(input entry_t e);
      while (busy_e) begin
         @(negedge clk);                          // Mul/div still running
      end
      valid_op_e = 1'b1;
      opcode_e   = e.op;
      a_e        = e.a;
      b_e        = e.b;
      test_name  = e.name;
      exp_known  = e.known;
      exp_val    = e.exp;
      exp_div0   = e.div0;
      hold_e     = (e.hold != 0);
      repeat (e.hold) @(negedge clk);
      hold_e     = 1'b0;
      @(negedge clk);                             // Accepted at the edge in between
      valid_op_e = 1'b0;
   endtask

   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      valid_op_e = 1'b0;
      hold_e     = 1'b0;
      opcode_e   = OP_ADD;
      a_e        = '0;
      b_e        = '0;
      test_name  = "reset";
      exp_known  = 1'b0;
      exp_val    = '0;
      exp_div0   = 1'b0;
      seed       = 32'h697b;
      built      = 1'b0;
      build_table();
      built      = 1'b1;
      repeat (10) @(negedge clk);
      reset      = 1'b0;
      foreach (tbl[i]) begin
         apply_entry(tbl[i]);
      end
      while (busy_e) begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);                  // Let the last result drain
      asrt_fails = dut_i.asserts_i.fails;
      if (pending != 0) begin
         $display("Stimulus ended with %0d results never returned", pending);
      end
      $display("Error counts: %0d value, %0d protocol, %0d assertion",
               val_errs, other_errs, asrt_fails);
      if (val_errs == 0 && other_errs == 0 && asrt_fails == 0 && pending == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Watchdog sized for a full mul/div plus hold and slack per entry
   initial begin
      wait (built === 1'b1);
      limit = tbl.size() * (IMDR_STEPS + 10) + 200;
      repeat (limit) @(posedge clk);
      $display("Timeout: run still going after %0d cycles", limit);
      $display("** FAIL **");
      $finish;
   end

endmodule
